//--- source/memOpPkg.sv
`default_nettype none

package memOpPkg;

    typedef enum logic {
        LOAD  = 1'b0,
        STORE = 1'b1
    } memOpcode;

    // Wraps around, so age is the signed difference
    typedef logic [5:0] sqNum;

    typedef struct packed {
        logic valid;
        memOpcode opcode;
        logic [31:0] addr;
        sqNum sqN;
        logic fault;
    } aguUop;

    typedef struct packed {
        logic taken;
        sqNum sqN;
    } branchProv;

    // Op is younger than a taken branch
    function automatic logic isFlushed(branchProv br, sqNum sqN);
        sqNum diff;
        diff = sqN - br.sqN;
        return br.taken && ($signed(diff) > 0);
    endfunction

endpackage

`default_nettype wire

//--- source/vmemPkg.sv
`default_nettype none

package vmemPkg;

    typedef struct packed {
        logic sv32en;
        logic [19:0] rootPpn;
    } virtMemState;

    typedef struct packed {
        logic valid;
        logic [19:0] vpn;
    } walkReq;

    typedef struct packed {
        logic valid;
        logic [19:0] vpn;
        logic [19:0] ppn;
        logic isSuperPage;
        logic fault;
    } walkRes;

    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        LEVEL1 = 2'd1,
        LEVEL0 = 2'd2,
        DONE   = 2'd3
    } walkState;

    // Sv32 PTE layout, only the low 20 PPN bits are kept
    localparam int PTE_V = 0;
    localparam int PTE_R = 1;
    localparam int PTE_X = 3;
    localparam int PTE_PPN_LO = 10;
    localparam int PTE_PPN_HI = 29;

    // Superpage compares VPN[1] only
    function automatic logic pageMatch(logic [19:0] vpn, logic isSuperPage, logic [31:0] addr);
        if (isSuperPage) begin
            return vpn[19:10] == addr[31:22];
        end
        return vpn == addr[31:12];
    endfunction

endpackage

`default_nettype wire

//--- source/tlbMissQueue.sv
`timescale 1ns/1ps
`default_nettype none

module tlbMissQueue #(
    parameter int QUEUE_SIZE = 4
) (
    input  wire logic clk,
    input  wire logic rst,
    input  wire memOpPkg::branchProv branch,
    input  wire vmemPkg::virtMemState vmem,
    input  wire vmemPkg::walkRes walkRes,
    input  wire logic walkActive,
    output logic stall,
    input  wire logic enqueue,
    input  wire logic uopReady,
    input  wire memOpPkg::aguUop uop,
    input  wire logic dequeue,
    output memOpPkg::aguUop queueUop
);
    import memOpPkg::*;
    import vmemPkg::*;

    localparam int IDX_W = (QUEUE_SIZE > 1) ? $clog2(QUEUE_SIZE) : 1;

    aguUop slots [QUEUE_SIZE];
    logic [QUEUE_SIZE-1:0] ready;

    logic [IDX_W-1:0] idxIn;
    logic idxInValid;
    logic [IDX_W-1:0] idxOut;
    logic idxOutValid;

    assign stall = !idxInValid;

    // Free slot
    always_comb begin
        idxIn = '0;
        idxInValid = 1'b0;
        for (int i = 0; i < QUEUE_SIZE; i++) begin
            if (!slots[i].valid) begin
                idxIn = IDX_W'(i);
                idxInValid = 1'b1;
            end
        end
    end

    // Idle walker lets an unresolved op through to start a walk
    always_comb begin
        idxOut = '0;
        idxOutValid = 1'b0;
        for (int i = 0; i < QUEUE_SIZE; i++) begin
            if (slots[i].valid && (ready[i] || !walkActive)) begin
                idxOut = IDX_W'(i);
                idxOutValid = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < QUEUE_SIZE; i++) begin
                slots[i].valid <= 1'b0;
            end
            ready <= '0;
            queueUop.valid <= 1'b0;
        end else begin
            // Wake ops on the page just walked
            if (walkRes.valid) begin
                for (int i = 0; i < QUEUE_SIZE; i++) begin
                    if (slots[i].valid &&
                        pageMatch(walkRes.vpn, walkRes.isSuperPage, slots[i].addr)) begin
                        ready[i] <= 1'b1;
                    end
                end
            end

            for (int i = 0; i < QUEUE_SIZE; i++) begin
                if (slots[i].valid && isFlushed(branch, slots[i].sqN)) begin
                    slots[i].valid <= 1'b0;
                end
            end

            if (enqueue && uop.valid && idxInValid && !isFlushed(branch, uop.sqN)) begin
                slots[idxIn] <= uop;
                ready[idxIn] <= !vmem.sv32en || uopReady;
            end

            if (dequeue || isFlushed(branch, queueUop.sqN)) begin
                queueUop.valid <= 1'b0;
            end
            if ((!queueUop.valid || dequeue) && idxOutValid &&
                !isFlushed(branch, slots[idxOut].sqN)) begin
                queueUop <= slots[idxOut];
                slots[idxOut].valid <= 1'b0;
                ready[idxOut] <= 1'b0;
            end
        end
    end

    // AGU must hold off while full
    assert property (@(posedge clk) disable iff (rst)
        enqueue |-> !stall);

    // Flushed ops never reach the replay stage
    assert property (@(posedge clk) disable iff (rst)
        branch.taken |=> !(queueUop.valid && isFlushed($past(branch), queueUop.sqN)));

endmodule

`default_nettype wire

//--- source/pageWalker.sv
`timescale 1ns/1ps
`default_nettype none

module pageWalker (
    input  wire logic clk,
    input  wire logic rst,
    input  wire vmemPkg::virtMemState vmem,
    input  wire vmemPkg::walkReq walkReq,
    output logic walkActive,
    output logic memReq,
    output logic [31:0] memAddr,
    input  wire logic memAck,
    input  wire logic [31:0] memData,
    output vmemPkg::walkRes walkRes
);
    import vmemPkg::*;

    walkState state;
    logic pteValid;
    logic pteLeaf;

    assign walkActive = (state != IDLE);
    assign memReq = (state == LEVEL1) || (state == LEVEL0);

    assign pteValid = memData[PTE_V];
    assign pteLeaf = memData[PTE_R] || memData[PTE_X];

    always_ff @(posedge clk) begin
        walkRes.valid <= 1'b0;
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (walkReq.valid && vmem.sv32en) begin
                        walkRes.vpn <= walkReq.vpn;
                        memAddr <= {vmem.rootPpn, walkReq.vpn[19:10], 2'b00};
                        state <= LEVEL1;
                    end
                end
                LEVEL1: begin
                    if (memAck) begin
                        if (pteValid && !pteLeaf) begin
                            memAddr <= {memData[PTE_PPN_HI:PTE_PPN_LO], walkRes.vpn[9:0], 2'b00};
                            state <= LEVEL0;
                        end else begin
                            // Leaf or hole here covers the whole 4 MiB region
                            walkRes.ppn <= memData[PTE_PPN_HI:PTE_PPN_LO];
                            walkRes.isSuperPage <= 1'b1;
                            walkRes.fault <= !pteValid;
                            state <= DONE;
                        end
                    end
                end
                LEVEL0: begin
                    if (memAck) begin
                        walkRes.ppn <= memData[PTE_PPN_HI:PTE_PPN_LO];
                        walkRes.isSuperPage <= 1'b0;
                        walkRes.fault <= !(pteValid && pteLeaf);
                        state <= DONE;
                    end
                end
                DONE: begin
                    walkRes.valid <= 1'b1;
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        memReq && !memAck |=> memReq && $stable(memAddr));

    // Replay stage keeps a single walk in flight
    assert property (@(posedge clk) disable iff (rst)
        walkReq.valid |-> state == IDLE);

endmodule

`default_nettype wire

//--- source/missReplay.sv
`timescale 1ns/1ps
`default_nettype none

module missReplay #(
    parameter int TLB_ENTRIES = 4
) (
    input  wire logic clk,
    input  wire logic rst,
    input  wire memOpPkg::branchProv branch,
    input  wire vmemPkg::virtMemState vmem,
    input  wire memOpPkg::aguUop queueUop,
    output logic dequeue,
    output vmemPkg::walkReq walkReq,
    input  wire vmemPkg::walkRes walkRes,
    input  wire logic outReady,
    output memOpPkg::aguUop outUop
);
    import memOpPkg::*;
    import vmemPkg::*;

    localparam int TLB_W = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1;

    typedef struct packed {
        logic [19:0] vpn;
        logic [19:0] ppn;
        logic isSuperPage;
    } tlbEntry;

    tlbEntry tlb [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] tlbValid;
    logic [TLB_W-1:0] fillPtr;

    // Op parked while its walk runs, or translated but blocked by the output
    aguUop pending;
    logic pendingWait;
    logic walkBusy;

    logic outFree;
    logic hit;
    logic [TLB_W-1:0] hitIdx;
    logic needWalk;
    logic resMatch;
    aguUop nextOut;
    logic loadOut;

    function automatic aguUop applyPage(aguUop u, logic [19:0] ppn, logic isSuper, logic fault);
        aguUop r;
        r = u;
        r.fault = fault;
        if (!fault) begin
            if (isSuper) begin
                r.addr = {ppn[19:10], u.addr[21:0]};
            end else begin
                r.addr = {ppn, u.addr[11:0]};
            end
        end
        return r;
    endfunction

    always_comb begin
        hit = 1'b0;
        hitIdx = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (tlbValid[i] && pageMatch(tlb[i].vpn, tlb[i].isSuperPage, queueUop.addr)) begin
                hit = 1'b1;
                hitIdx = TLB_W'(i);
            end
        end
    end

    assign outFree = !outUop.valid || outReady;
    assign needWalk = vmem.sv32en && !hit;
    assign resMatch = walkRes.valid && pending.valid && pendingWait &&
        pageMatch(walkRes.vpn, walkRes.isSuperPage, pending.addr);

    // Misses only need the walker, hits and bare ops need the output slot
    always_comb begin
        dequeue = 1'b0;
        if (queueUop.valid && !pending.valid && !isFlushed(branch, queueUop.sqN)) begin
            dequeue = needWalk ? !walkBusy : outFree;
        end
    end

    assign walkReq.valid = dequeue && needWalk;
    assign walkReq.vpn = queueUop.addr[31:12];

    always_comb begin
        if (pending.valid && !pendingWait) begin
            nextOut = pending;
        end else if (resMatch) begin
            nextOut = applyPage(pending, walkRes.ppn, walkRes.isSuperPage, walkRes.fault);
        end else if (vmem.sv32en) begin
            nextOut = applyPage(queueUop, tlb[hitIdx].ppn, tlb[hitIdx].isSuperPage, 1'b0);
        end else begin
            nextOut = queueUop;
        end
        loadOut = outFree && !isFlushed(branch, nextOut.sqN) &&
            ((pending.valid && !pendingWait) || resMatch || (dequeue && !needWalk));
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            outUop.valid <= 1'b0;
            pending.valid <= 1'b0;
            pendingWait <= 1'b0;
            walkBusy <= 1'b0;
            tlbValid <= '0;
            fillPtr <= '0;
        end else begin
            if (walkReq.valid) begin
                walkBusy <= 1'b1;
            end else if (walkRes.valid) begin
                walkBusy <= 1'b0;
            end

            // Round robin fill
            if (walkRes.valid && !walkRes.fault) begin
                tlb[fillPtr] <= '{vpn: walkRes.vpn, ppn: walkRes.ppn,
                                  isSuperPage: walkRes.isSuperPage};
                tlbValid[fillPtr] <= 1'b1;
                fillPtr <= (fillPtr == TLB_W'(TLB_ENTRIES - 1)) ? '0 : fillPtr + 1'b1;
            end

            if (outFree || isFlushed(branch, outUop.sqN)) begin
                outUop.valid <= 1'b0;
            end
            if (loadOut) begin
                outUop <= nextOut;
            end

            if (dequeue && needWalk) begin
                pending <= queueUop;
                pendingWait <= 1'b1;
            end else if (resMatch && !outFree) begin
                pending <= applyPage(pending, walkRes.ppn, walkRes.isSuperPage, walkRes.fault);
                pendingWait <= 1'b0;
            end else if (outFree && (resMatch || (pending.valid && !pendingWait))) begin
                pending.valid <= 1'b0;
            end
            if (pending.valid && isFlushed(branch, pending.sqN)) begin
                pending.valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/translateUnit.sv
`timescale 1ns/1ps
`default_nettype none

module translateUnit #(
    parameter int QUEUE_SIZE = 4,
    parameter int TLB_ENTRIES = 4
) (
    input  wire logic clk,
    input  wire logic rst,
    input  wire memOpPkg::branchProv branch,
    input  wire vmemPkg::virtMemState vmem,
    input  wire logic enqueue,
    input  wire logic uopReady,
    input  wire memOpPkg::aguUop uop,
    output logic stall,
    output logic memReq,
    output logic [31:0] memAddr,
    input  wire logic memAck,
    input  wire logic [31:0] memData,
    input  wire logic outReady,
    output memOpPkg::aguUop outUop
);
    import memOpPkg::*;
    import vmemPkg::*;

    aguUop queueUop;
    logic dequeue;
    walkReq walkRequest;
    walkRes walkResult;
    logic walkActive;

    tlbMissQueue #(
        .QUEUE_SIZE(QUEUE_SIZE)
    ) u_queue (
        .clk(clk),
        .rst(rst),
        .branch(branch),
        .vmem(vmem),
        .walkRes(walkResult),
        .walkActive(walkActive),
        .stall(stall),
        .enqueue(enqueue),
        .uopReady(uopReady),
        .uop(uop),
        .dequeue(dequeue),
        .queueUop(queueUop)
    );

    pageWalker u_walker (
        .clk(clk),
        .rst(rst),
        .vmem(vmem),
        .walkReq(walkRequest),
        .walkActive(walkActive),
        .memReq(memReq),
        .memAddr(memAddr),
        .memAck(memAck),
        .memData(memData),
        .walkRes(walkResult)
    );

    missReplay #(
        .TLB_ENTRIES(TLB_ENTRIES)
    ) u_replay (
        .clk(clk),
        .rst(rst),
        .branch(branch),
        .vmem(vmem),
        .queueUop(queueUop),
        .dequeue(dequeue),
        .walkReq(walkRequest),
        .walkRes(walkResult),
        .outReady(outReady),
        .outUop(outUop)
    );

endmodule

`default_nettype wire

//--- tests/translateUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module translateUnitTb;
    import memOpPkg::*;
    import vmemPkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int QUEUE_SIZE = 4;
    localparam int NUM_OPS = 50;

    // Page table image
    localparam logic [19:0] ROOT_PPN = 20'h00010;
    localparam logic [19:0] L0_PPN = 20'h00020;
    localparam logic [19:0] SUPER_PPN = 20'h80000;
    localparam logic [19:0] PAGE_A = 20'h12345;
    localparam logic [19:0] PAGE_B = 20'h0abcd;

    logic clk = 1'b0;
    logic rst;
    branchProv branch;
    virtMemState vmem;
    logic enqueue;
    logic uopReady;
    aguUop uop;
    logic stall;
    logic memReq;
    logic [31:0] memAddr;
    logic memAck = 1'b0;
    logic [31:0] memData = 32'h0;
    logic outReady = 1'b0;
    aguUop outUop;

    // Scoreboard indexed by sqN
    logic [31:0] expAddr [64];
    logic expFault [64];
    memOpcode expOp [64];
    logic live [64];

    sqNum nextSq;
    sqNum ageDiff;
    logic [2:0] memWait = 3'd0;
    logic [31:0] lastRead = 32'h0;
    logic forceLow;
    int valueErrors = 0;
    int protocolErrors = 0;
    int fillCount;

    translateUnit u_dut (
        .clk(clk),
        .rst(rst),
        .branch(branch),
        .vmem(vmem),
        .enqueue(enqueue),
        .uopReady(uopReady),
        .uop(uop),
        .stall(stall),
        .memReq(memReq),
        .memAddr(memAddr),
        .memAck(memAck),
        .memData(memData),
        .outReady(outReady),
        .outUop(outUop)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] pteAt(logic [31:0] a);
        case (a)
            {ROOT_PPN, 10'd1, 2'b00}: return {2'b00, SUPER_PPN, 10'h00b};
            {ROOT_PPN, 10'd2, 2'b00}: return {2'b00, L0_PPN, 10'h001};
            {L0_PPN, 10'd5, 2'b00}: return {2'b00, PAGE_A, 10'h003};
            {L0_PPN, 10'd6, 2'b00}: return {2'b00, PAGE_B, 10'h003};
            default: return 32'h0;
        endcase
    endfunction

    // Reference Sv32 walk over the page table image
    task automatic refTranslate(input logic [31:0] va, output logic [31:0] pa,
                                output logic flt);
        logic [31:0] l1;
        logic [31:0] l0;
        pa = va;
        flt = 1'b1;
        l1 = pteAt({ROOT_PPN, va[31:22], 2'b00});
        if (l1[0] && (l1[1] || l1[3])) begin
            pa = {l1[29:20], va[21:0]};
            flt = 1'b0;
        end else if (l1[0]) begin
            l0 = pteAt({l1[29:10], va[21:12], 2'b00});
            if (l0[0] && (l0[1] || l0[3])) begin
                pa = {l0[29:10], va[11:0]};
                flt = 1'b0;
            end
        end
    endtask

    function automatic logic [31:0] randAddr();
        case ($urandom_range(0, 4))
            0: return {10'd1, 22'($urandom)};
            1: return {10'd2, 10'd5, 12'($urandom)};
            2: return {10'd2, 10'd6, 12'($urandom)};
            3: return {10'd2, 10'd7, 12'($urandom)};
            default: return {10'd3, 22'($urandom)};
        endcase
    endfunction

    // Page table memory with 1 to 4 cycles of latency
    always @(posedge clk) begin
        if (rst) begin
            memAck <= 1'b0;
            memWait <= 3'd0;
        end else if (memAck) begin
            memAck <= 1'b0;
        end else if (memReq) begin
            if (memWait == 3'd0) begin
                memWait <= 3'($urandom_range(1, 4));
            end else if (memWait == 3'd1) begin
                memAck <= 1'b1;
                memData <= pteAt(memAddr);
                lastRead <= memAddr;
                memWait <= 3'd0;
            end else begin
                memWait <= memWait - 3'd1;
            end
        end
    end

    always @(posedge clk) begin
        if (rst || forceLow) begin
            outReady <= 1'b0;
        end else begin
            outReady <= 1'($urandom_range(0, 1));
        end
    end

    // Retire and flush bookkeeping
    always @(posedge clk) begin
        if (!rst && outUop.valid && outReady) begin
            live[outUop.sqN] <= 1'b0;
        end
        if (!rst && branch.taken) begin
            for (int i = 0; i < 64; i++) begin
                ageDiff = sqNum'(i) - branch.sqN;
                if ($signed(ageDiff) > 0) begin
                    live[i] <= 1'b0;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        outUop.valid && outReady |-> live[outUop.sqN])
    else begin
        protocolErrors++;
        $display("Op with sqN %0d left the unit although it was flushed or already retired",
            $sampled(outUop.sqN));
    end

    assert property (@(posedge clk) disable iff (rst)
        outUop.valid && outReady |-> outUop.addr == expAddr[outUop.sqN])
    else begin
        valueErrors++;
        $display("Fail %0t outUop.addr expected %h actual %h", $time,
            expAddr[$sampled(outUop.sqN)], $sampled(outUop.addr));
    end

    assert property (@(posedge clk) disable iff (rst)
        outUop.valid && outReady |-> outUop.fault == expFault[outUop.sqN])
    else begin
        valueErrors++;
        $display("Fail %0t outUop.fault expected %b actual %b", $time,
            expFault[$sampled(outUop.sqN)], $sampled(outUop.fault));
    end

    assert property (@(posedge clk) disable iff (rst)
        outUop.valid && outReady |-> outUop.opcode == expOp[outUop.sqN])
    else begin
        valueErrors++;
        $display("Fail %0t outUop.opcode expected %b actual %b", $time,
            expOp[$sampled(outUop.sqN)], $sampled(outUop.opcode));
    end

    assert property (@(posedge clk) disable iff (rst)
        outUop.valid && !outReady && !branch.taken |=> outUop.valid && $stable(outUop))
    else begin
        valueErrors++;
        $display("Fail %0t outUop expected %h actual %h", $time,
            $past(outUop), $sampled(outUop));
    end

    assert property (@(posedge clk) disable iff (rst)
        memReq && !memAck |=> $stable(memAddr))
    else begin
        valueErrors++;
        $display("Fail %0t memAddr expected %h actual %h", $time,
            $past(memAddr), $sampled(memAddr));
    end

    // Level 0 reads only follow the pointer entry for VPN[1] = 2
    assert property (@(posedge clk) disable iff (rst)
        memReq && !memAck && memAddr[31:12] == L0_PPN |->
            lastRead == {ROOT_PPN, 10'd2, 2'b00})
    else begin
        valueErrors++;
        $display("Fail %0t lastRead expected %h actual %h", $time,
            {ROOT_PPN, 10'd2, 2'b00}, $sampled(lastRead));
    end

    assert property (@(posedge clk) disable iff (rst)
        memReq |-> memAddr[31:12] == ROOT_PPN || memAddr[31:12] == L0_PPN)
    else begin
        valueErrors++;
        $display("Fail %0t memAddr expected page %h or %h actual %h", $time,
            ROOT_PPN, L0_PPN, $sampled(memAddr));
    end

    assert property (@(posedge clk) disable iff (rst)
        !vmem.sv32en |-> !memReq)
    else begin
        protocolErrors++;
        $display("Page table read issued with translation off");
    end

    task automatic enqueueOp(input logic [31:0] va);
        logic [31:0] pa;
        logic flt;
        memOpcode op;
        @(negedge clk);
        while (stall) @(negedge clk);
        if (vmem.sv32en) begin
            refTranslate(va, pa, flt);
        end else begin
            pa = va;
            flt = 1'b0;
        end
        op = memOpcode'($urandom_range(0, 1));
        @(posedge clk);
        enqueue <= 1'b1;
        uopReady <= 1'($urandom_range(0, 1));
        uop <= '{valid: 1'b1, opcode: op, addr: va, sqN: nextSq, fault: 1'b0};
        expAddr[nextSq] <= pa;
        expFault[nextSq] <= flt;
        expOp[nextSq] <= op;
        live[nextSq] <= 1'b1;
        nextSq = nextSq + 6'd1;
        @(posedge clk);
        enqueue <= 1'b0;
    endtask

    function automatic logic anyLive();
        for (int i = 0; i < 64; i++) begin
            if (live[i]) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // A walk for a flushed op may still be reading
    task automatic drain();
        @(posedge clk);
        while (anyLive() || memReq) @(posedge clk);
    endtask

    initial begin
        #(NUM_OPS * 40 * CLK_PERIOD);
        $display("Watchdog expired before all operations left the unit");
        $display("Errors: value %0d, protocol %0d", valueErrors, protocolErrors);
        $display("Test failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h8672_3395));
        for (int i = 0; i < 64; i++) begin
            live[i] = 1'b0;
        end
        rst = 1'b1;
        branch = '0;
        vmem = '{sv32en: 1'b1, rootPpn: ROOT_PPN};
        enqueue = 1'b0;
        uopReady = 1'b0;
        uop = '0;
        nextSq = '0;
        forceLow = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // Sv32 translation with random back-pressure
        for (int i = 0; i < 24; i++) begin
            enqueueOp(randAddr());
        end
        drain();

        // Branch flush while ops are held in flight
        forceLow <= 1'b1;
        for (int i = 0; i < 5; i++) begin
            enqueueOp(randAddr());
        end
        @(posedge clk);
        branch <= '{taken: 1'b1, sqN: nextSq - 6'd4};
        @(posedge clk);
        branch <= '0;
        forceLow <= 1'b0;
        drain();

        // Bare mode
        @(posedge clk);
        vmem <= '{sv32en: 1'b0, rootPpn: ROOT_PPN};
        for (int i = 0; i < 12; i++) begin
            enqueueOp($urandom);
        end
        drain();

        // Output held off until the queue stalls
        forceLow <= 1'b1;
        fillCount = 0;
        @(negedge clk);
        while (!stall && fillCount < 10) begin
            enqueueOp($urandom);
            fillCount++;
            @(negedge clk);
        end
        assert (stall && fillCount <= QUEUE_SIZE + 2)
        else begin
            protocolErrors++;
            $display("Queue took %0d ops with the output blocked and stall is %b",
                fillCount, stall);
        end
        forceLow <= 1'b0;
        drain();

        repeat (4) @(posedge clk);
        $display("Errors: value %0d, protocol %0d", valueErrors, protocolErrors);
        if (valueErrors + protocolErrors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
source/memOpPkg.sv
source/vmemPkg.sv
source/tlbMissQueue.sv
source/pageWalker.sv
source/missReplay.sv
source/translateUnit.sv
tests/translateUnitTb.sv

//--- run.sh
#!/bin/sh
# Build and run the translateUnit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module translateUnitTb -o translateUnitSim > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/translateUnitSim > sim.log 2>&1
grep -q "Test completed successfully" sim.log \
    && echo "PASS" \
    || { echo "FAIL, see sim.log"; exit 1; }
